//--- dv/mdio_trace.txt
# T name | W addr data | R addr expected | WF reg data | RF reg | P phy read data
# D waits for frame end | K checks command readback | O pin value | I phy_int | N cycles
T reset
R 00 00000000
R 04 00000000
R 08 00000001
R 0c 00000000
R 10 00000000
R 14 00000000
O phyrst 1
O irq 0
W 00 00000001
O phyrst 0
R 00 00000001
T write_frame
WF 03 1234
R 14 00000001
D
R 14 00000000
K
T read_frame
P a5c3
RF 11
D
K
T busy_drop
WF 05 beef
WF 06 0f0f
K
R 14 00000001
D
N 200
T irq
W 04 00000001
O irq 1
WF 0a 5555
O irq 0
D
O irq 1
W 04 00000002
O irq 0
I 1
N 4
O irq 1
I 0
N 4
O irq 0

//--- filelist.f
logic/regs_pkg.sv
logic/mdio_pkg.sv
logic/mdio_cmd_if.sv
logic/mdio_regs.sv
logic/mdc_timer.sv
logic/mdio_sequencer.sv
logic/mdio_shifter.sv
logic/mdio_top.sv
dv/tb_clock.sv
dv/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the MDIO testbench with Verilator from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f filelist.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- dv/tb_top.sv
// Trace-driven test of the MDIO master; run from the project root so dv/mdio_trace.txt is found
`timescale 1ns/1ps

module tb_top
    import regs_pkg::*, mdio_pkg::*;
();

    localparam int MDC_HALF        = 4;
    localparam int FRAME_RISES     = PREAMBLE_BITS + FRAME_BITS;
    localparam int DATA_FIRST_RISE = FRAME_RISES - $bits(mdio_data_t);
    localparam int HEADER_LOW      = FRAME_BITS - READ_RELEASE_BIT;

    logic        clock;
    logic        reset;
    logic        reg_wr;
    logic        reg_rd;
    reg_addr_t   reg_addr;
    reg_data_t   reg_wdata;
    reg_data_t   reg_rdata;
    logic        reg_rvalid;
    logic        mdc;
    logic        mdio_out;
    logic        mdio_oe;
    logic        mdio_in;
    logic        phy_reset;
    logic        phy_int;
    logic        irq;

    logic [31:0] rng_state;
    mdio_frame_t exp_frame;
    logic        exp_read;
    logic        in_flight;
    mdio_data_t  phy_data;
    int          frames_expected;
    int          checks;
    int          errors;
    int          tests;
    int          tests_failed;
    int          test_errs;
    string       cur_test;
    int          cycles;
    int          cycle_limit;
    string       lines[$];

    // PHY model state
    logic [63:0] cap;
    int          cap_bits;
    int          rise_cnt;
    int          frames_seen;
    logic        mdc_prev = 1'b0;
    logic        oe_prev  = 1'b0;

    tb_clock #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (4)
    ) clk0 (
        .clock (clock),
        .reset (reset)
    );

    mdio_top #(
        .MDC_HALF_CYCLES (MDC_HALF)
    ) dut0 (
        .clock        (clock),
        .reset        (reset),
        .reg_wr_i     (reg_wr),
        .reg_rd_i     (reg_rd),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_rdata_o  (reg_rdata),
        .reg_rvalid_o (reg_rvalid),
        .mdc_o        (mdc),
        .mdio_o       (mdio_out),
        .mdio_oe_o    (mdio_oe),
        .mdio_i       (mdio_in),
        .phy_reset_o  (phy_reset),
        .phy_int_i    (phy_int),
        .irq_o        (irq)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic is_space(input byte c);
        return c == " " || c == "\t" || c == "\n" || c == "\r";
    endfunction

    function automatic string token(input string s, input int idx);
        int pos;
        int start;
        int count;
        pos = 0;
        count = 0;
        while (pos < s.len()) begin
            while (pos < s.len() && is_space(s.getc(pos))) begin
                pos++;
            end
            start = pos;
            while (pos < s.len() && !is_space(s.getc(pos))) begin
                pos++;
            end
            if (pos > start) begin
                if (count == idx) return s.substr(start, pos - 1);
                count++;
            end
        end
        return "";
    endfunction

    task automatic count_error();
        errors++;
        test_errs++;
    endtask

    task automatic check_word(input string what, input reg_data_t got, input reg_data_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            count_error();
        end
    endtask

    task automatic check_frame(input string what, input mdio_frame_t got,
                               input mdio_frame_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            count_error();
        end
    endtask

    task automatic check_data(input string what, input mdio_data_t got, input mdio_data_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            count_error();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t ns: %s: got %b, expected %b", $time, what, got, exp);
            count_error();
        end
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        reg_addr  = addr;
        reg_wdata = data;
        reg_wr    = 1'b1;
        @(posedge clock);
        #1;
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        int waited;
        reg_addr = addr;
        reg_rd   = 1'b1;
        @(posedge clock);
        #1;
        reg_rd = 1'b0;
        waited = 0;
        while (!reg_rvalid && waited < 4) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (!reg_rvalid) begin
            $display("read of register %h got no response", addr);
            count_error();
        end
        data = reg_rdata;
    endtask

    task automatic issue_frame(input logic is_read, input logic [4:0] reg_sel,
                               input mdio_data_t data);
        mdio_frame_t f;
        rng_state  = next_random(rng_state);
        f.st       = 2'b01;
        f.op       = is_read ? MDIO_OP_READ : MDIO_OP_WRITE;
        f.phy_addr = rng_state[4:0];
        f.reg_addr = reg_sel;
        f.ta       = is_read ? 2'b11 : 2'b10;
        f.data     = is_read ? '0 : data;
        reg_write(REG_MDIO_CMD, reg_data_t'(f));
        // Command during a frame is dropped
        if (!in_flight) begin
            in_flight = 1'b1;
            exp_frame = f;
            exp_read  = is_read;
            frames_expected++;
        end
    endtask

    task automatic wait_frame_end();
        reg_data_t   status;
        reg_data_t   rdata;
        mdio_frame_t got;
        mdio_frame_t want;
        if (!in_flight) begin
            $display("test %s waits for a frame that was never started", cur_test);
            count_error();
        end else begin
            do begin
                reg_read(REG_STATUS, status);
            end while (status[STATUS_BUSY_BIT]);
            in_flight = 1'b0;
            if (exp_read) begin
                check_word("bits driven in read frame", reg_data_t'(cap_bits),
                           reg_data_t'(PREAMBLE_BITS + READ_RELEASE_BIT));
                check_word("read preamble", cap[READ_RELEASE_BIT +: PREAMBLE_BITS],
                           32'hFFFF_FFFF);
                got = '0;
                got[FRAME_BITS-1 -: READ_RELEASE_BIT] = cap[READ_RELEASE_BIT-1:0];
                want = exp_frame;
                want[HEADER_LOW-1:0] = '0;
                check_frame("read frame header", got, want);
                reg_read(REG_MDIO_RDATA, rdata);
                check_data("read data", rdata[15:0], phy_data);
            end else begin
                check_word("bits driven in write frame", reg_data_t'(cap_bits),
                           reg_data_t'(FRAME_RISES));
                check_word("write preamble", cap[FRAME_RISES-1:FRAME_BITS], 32'hFFFF_FFFF);
                check_frame("write frame", mdio_frame_t'(cap[FRAME_BITS-1:0]), exp_frame);
            end
        end
    endtask

    task automatic finish_test();
        if (cur_test.len() > 0) begin
            if (frames_seen != frames_expected) begin
                $display("test %s: the PHY saw %0d frames but %0d were accepted",
                         cur_test, frames_seen, frames_expected);
                count_error();
            end
            tests++;
            if (test_errs == 0) begin
                $display("test %s: ok", cur_test);
            end else begin
                tests_failed++;
                $display("test %s: %0d errors", cur_test, test_errs);
            end
        end
        test_errs = 0;
    endtask

    task automatic run_line(input string line);
        string       cmd;
        string       arg1;
        string       arg2;
        logic [31:0] a;
        logic [31:0] b;
        reg_data_t   got;
        cmd  = token(line, 0);
        arg1 = token(line, 1);
        arg2 = token(line, 2);
        a    = arg1.atohex();
        b    = arg2.atohex();
        if (cmd == "T") begin
            finish_test();
            cur_test = arg1;
        end else if (cmd == "W") begin
            reg_write(reg_addr_t'(a[7:0]), b);
        end else if (cmd == "R") begin
            reg_read(reg_addr_t'(a[7:0]), got);
            check_word($sformatf("read of register %h", a[7:0]), got, b);
        end else if (cmd == "WF") begin
            issue_frame(1'b0, a[4:0], b[15:0]);
        end else if (cmd == "RF") begin
            issue_frame(1'b1, a[4:0], '0);
        end else if (cmd == "P") begin
            phy_data = a[15:0];
        end else if (cmd == "D") begin
            wait_frame_end();
        end else if (cmd == "K") begin
            reg_read(REG_MDIO_CMD, got);
            check_frame("command readback", mdio_frame_t'(got), exp_frame);
        end else if (cmd == "O" && arg1 == "irq") begin
            check_bit("irq_o", irq, b[0]);
        end else if (cmd == "O" && arg1 == "phyrst") begin
            check_bit("phy_reset_o", phy_reset, b[0]);
        end else if (cmd == "I") begin
            phy_int = a[0];
        end else if (cmd == "N") begin
            repeat (a) begin
                @(posedge clock);
                #1;
            end
        end else begin
            $display("trace line not understood: %s", line);
            count_error();
        end
    endtask

    // PHY model samples on rising MDC and drives read data after falling MDC
    always @(posedge clock) begin
        #1;
        if (mdio_oe && !oe_prev) begin
            frames_seen++;
            rise_cnt = 0;
            cap      = '0;
            cap_bits = 0;
        end
        if (mdc && !mdc_prev) begin
            if (mdio_oe) begin
                cap = {cap[62:0], mdio_out};
                cap_bits++;
            end
            rise_cnt++;
        end
        if (!mdc && mdc_prev) begin
            if (!mdio_oe && rise_cnt >= DATA_FIRST_RISE && rise_cnt < FRAME_RISES) begin
                mdio_in = phy_data[4'(FRAME_RISES - 1 - rise_cnt)];
            end else begin
                mdio_in = 1'b1;
            end
        end
        mdc_prev = mdc;
        oe_prev  = mdio_oe;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles in test %s", cycles, cur_test);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int    fd;
        int    n;
        string line;
        string first;
        reg_wr          = 1'b0;
        reg_rd          = 1'b0;
        reg_addr        = '0;
        reg_wdata       = '0;
        mdio_in         = 1'b1;
        phy_int         = 1'b0;
        rng_state       = 32'h1530_8832;
        exp_frame       = '0;
        exp_read        = 1'b0;
        in_flight       = 1'b0;
        phy_data        = '0;
        frames_expected = 0;
        cur_test        = "";
        cycle_limit     = 0;
        fd = $fopen("dv/mdio_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file dv/mdio_trace.txt");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                first = token(line, 0);
                if (n > 0 && first.len() > 0 && first.getc(0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
            cycle_limit = lines.size() * 2 * 65 * 2 * MDC_HALF + 100;
            @(negedge reset);
            foreach (lines[i]) begin
                run_line(lines[i]);
            end
            finish_test();
            $display("tests %0d, failed %0d, checks %0d, errors %0d",
                     tests, tests_failed, checks, errors);
            if (errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

//--- dv/tb_clock.sv
// Free-running clock from time zero; reset is released 1 ns after the last reset edge
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

//--- logic/mdio_top.sv
// MDIO master top; data line split into out, enable and in for an external pad buffer
`timescale 1ns/1ps

module mdio_top
    import regs_pkg::*, mdio_pkg::*;
#(
    parameter int MDC_HALF_CYCLES = 25
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      reg_wr_i,
    input  logic      reg_rd_i,
    input  reg_addr_t reg_addr_i,
    input  reg_data_t reg_wdata_i,
    output reg_data_t reg_rdata_o,
    output logic      reg_rvalid_o,
    output logic      mdc_o,
    output logic      mdio_o,
    output logic      mdio_oe_o,
    input  logic      mdio_i,
    output logic      phy_reset_o,
    input  logic      phy_int_i,
    output logic      irq_o
);

    mdio_cmd_if cmd ();

    logic       run;
    logic       tick;
    logic       load;
    logic       shift;
    logic       sample;
    logic       read_op;
    mdio_data_t rx_data;

    assign cmd.rdata = rx_data;
    assign read_op   = (cmd.frame.op == MDIO_OP_READ);

    mdio_regs regs0 (
        .clock        (clock),
        .reset        (reset),
        .reg_wr_i     (reg_wr_i),
        .reg_rd_i     (reg_rd_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .phy_int_i    (phy_int_i),
        .reg_rdata_o  (reg_rdata_o),
        .reg_rvalid_o (reg_rvalid_o),
        .phy_reset_o  (phy_reset_o),
        .irq_o        (irq_o),
        .cmd          (cmd.regs)
    );

    mdc_timer #(
        .MDC_HALF_CYCLES (MDC_HALF_CYCLES)
    ) timer0 (
        .clock  (clock),
        .reset  (reset),
        .run_i  (run),
        .tick_o (tick)
    );

    mdio_sequencer seq0 (
        .clock     (clock),
        .reset     (reset),
        .tick_i    (tick),
        .read_op_i (read_op),
        .run_o     (run),
        .mdc_o     (mdc_o),
        .mdio_oe_o (mdio_oe_o),
        .load_o    (load),
        .shift_o   (shift),
        .sample_o  (sample),
        .cmd       (cmd.engine)
    );

    mdio_shifter shifter0 (
        .clock     (clock),
        .reset     (reset),
        .load_i    (load),
        .shift_i   (shift),
        .sample_i  (sample),
        .frame_i   (cmd.frame),
        .mdio_i    (mdio_i),
        .tx_bit_o  (mdio_o),
        .rx_data_o (rx_data)
    );

endmodule

//--- logic/mdio_shifter.sv
// Transmit register idles at all ones, so the line shows preamble ones when unloaded
`timescale 1ns/1ps

module mdio_shifter
    import mdio_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        load_i,
    input  logic        shift_i,
    input  logic        sample_i,
    input  mdio_frame_t frame_i,
    input  logic        mdio_i,
    output logic        tx_bit_o,
    output mdio_data_t  rx_data_o
);

    logic [FRAME_BITS-1:0] tx_q;
    mdio_data_t            rx_q;

    // Ones fill in behind the frame
    always_ff @(posedge clock) begin
        if (reset) begin
            tx_q <= '1;
        end else if (load_i) begin
            tx_q <= frame_i;
        end else if (shift_i) begin
            tx_q <= {tx_q[FRAME_BITS-2:0], 1'b1};
        end
    end

    assign tx_bit_o = tx_q[FRAME_BITS-1];

    // Last sixteen samples of a frame are the data field
    always_ff @(posedge clock) begin
        if (sample_i) begin
            rx_q <= {rx_q[$bits(mdio_data_t)-2:0], mdio_i};
        end
    end

    assign rx_data_o = rx_q;

endmodule

//--- logic/mdio_sequencer.sv
// Frame FSM: 32 preamble bits then 32 frame bits, MDC rises on every second tick
`timescale 1ns/1ps

module mdio_sequencer
    import mdio_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       tick_i,
    input  logic       read_op_i,
    output logic       run_o,
    output logic       mdc_o,
    output logic       mdio_oe_o,
    output logic       load_o,
    output logic       shift_o,
    output logic       sample_o,
    mdio_cmd_if.engine cmd
);

    localparam logic [5:0] LAST_PREAMBLE = 6'(PREAMBLE_BITS - 1);
    localparam logic [5:0] FIRST_FRAME   = 6'(PREAMBLE_BITS);
    localparam logic [5:0] LAST_FRAME    = 6'(PREAMBLE_BITS + FRAME_BITS - 1);

    mdio_state_e state_q;
    logic [5:0]  bit_cnt_q;
    logic        rise_next_q;
    logic        busy_q;
    logic        done_q;

    assign cmd.busy = busy_q;
    assign cmd.done = done_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q     <= MDIO_IDLE;
            bit_cnt_q   <= '0;
            rise_next_q <= 1'b0;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            run_o       <= 1'b0;
            mdc_o       <= 1'b0;
            mdio_oe_o   <= 1'b0;
            load_o      <= 1'b0;
            shift_o     <= 1'b0;
            sample_o    <= 1'b0;
        end else begin
            load_o   <= 1'b0;
            shift_o  <= 1'b0;
            sample_o <= 1'b0;
            done_q   <= 1'b0;
            case (state_q)
                MDIO_IDLE: begin
                    if (cmd.start) begin
                        state_q     <= MDIO_PREAMBLE;
                        bit_cnt_q   <= '0;
                        rise_next_q <= 1'b0;
                        busy_q      <= 1'b1;
                        run_o       <= 1'b1;
                        mdio_oe_o   <= 1'b1;
                    end
                end
                MDIO_PREAMBLE, MDIO_FRAME: begin
                    if (tick_i) begin
                        rise_next_q <= !rise_next_q;
                        if (rise_next_q) begin
                            mdc_o     <= 1'b1;
                            sample_o  <= (state_q == MDIO_FRAME);
                            bit_cnt_q <= bit_cnt_q + 6'd1;
                            if (bit_cnt_q == LAST_PREAMBLE) begin
                                state_q <= MDIO_FRAME;
                            end else if (bit_cnt_q == LAST_FRAME) begin
                                state_q <= MDIO_FINISH;
                            end
                        end else begin
                            mdc_o <= 1'b0;
                            // Falling edge, so the next bit goes out
                            if (state_q == MDIO_FRAME) begin
                                load_o  <= (bit_cnt_q == FIRST_FRAME);
                                shift_o <= (bit_cnt_q != FIRST_FRAME);
                                if (read_op_i && bit_cnt_q[4:0] == 5'(READ_RELEASE_BIT)) begin
                                    mdio_oe_o <= 1'b0;
                                end
                            end
                        end
                    end
                end
                MDIO_FINISH: begin
                    // Closing half period, last shift empties the transmitter
                    if (tick_i) begin
                        state_q   <= MDIO_IDLE;
                        mdc_o     <= 1'b0;
                        shift_o   <= 1'b1;
                        mdio_oe_o <= 1'b0;
                        busy_q    <= 1'b0;
                        run_o     <= 1'b0;
                        done_q    <= 1'b1;
                    end
                end
                default: state_q <= MDIO_IDLE;
            endcase
        end
    end

    assert property (@(posedge clock) disable iff (reset) !busy_q |-> !mdio_oe_o);

endmodule

//--- logic/mdc_timer.sv
// Half-period pacer for MDC; needs MDC_HALF_CYCLES of 2 or more
`timescale 1ns/1ps

module mdc_timer #(
    parameter int MDC_HALF_CYCLES = 25
) (
    input  logic clock,
    input  logic reset,
    input  logic run_i,
    output logic tick_o
);

    localparam int               CNT_W  = $clog2(MDC_HALF_CYCLES);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(MDC_HALF_CYCLES - 1);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clock) begin
        if (reset || !run_i) begin
            cnt_q  <= RELOAD;
            tick_o <= 1'b0;
        end else if (cnt_q == '0) begin
            cnt_q  <= RELOAD;
            tick_o <= 1'b1;
        end else begin
            cnt_q  <= cnt_q - CNT_W'(1);
            tick_o <= 1'b0;
        end
    end

    // Tick is registered, so it must not outlive run
    assert property (@(posedge clock) disable iff (reset) tick_o |-> run_i);

endmodule

//--- logic/mdio_regs.sv
// Register block with single-cycle strobes; command writes while busy are dropped
`timescale 1ns/1ps

module mdio_regs
    import regs_pkg::*, mdio_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      reg_wr_i,
    input  logic      reg_rd_i,
    input  reg_addr_t reg_addr_i,
    input  reg_data_t reg_wdata_i,
    input  logic      phy_int_i,
    output reg_data_t reg_rdata_o,
    output logic      reg_rvalid_o,
    output logic      phy_reset_o,
    output logic      irq_o,
    mdio_cmd_if.regs  cmd
);

    reg_addr_e            addr;
    logic                 ctrl_q;
    logic [INT_COUNT-1:0] int_enable_q;
    logic [INT_COUNT-1:0] int_status;
    reg_data_t            cmd_q;
    mdio_data_t           rdata_q;
    logic [2:0]           phy_int_sync_q;
    reg_data_t            rd_mux;

    assign addr = reg_addr_e'(reg_addr_i);

    // Engine accepts a new frame only when idle
    assign cmd.start = reg_wr_i && (addr == REG_MDIO_CMD) && !cmd.busy;
    assign cmd.frame = mdio_frame_t'(cmd_q);

    always_ff @(posedge clock) begin
        if (reset) begin
            ctrl_q       <= 1'b0;
            int_enable_q <= '0;
            cmd_q        <= '0;
            rdata_q      <= '0;
        end else begin
            if (reg_wr_i && addr == REG_CTRL) begin
                ctrl_q <= reg_wdata_i[CTRL_PHY_RUN_BIT];
            end
            if (reg_wr_i && addr == REG_INT_ENABLE) begin
                int_enable_q <= reg_wdata_i[INT_COUNT-1:0];
            end
            if (cmd.start) begin
                cmd_q <= reg_wdata_i;
            end
            // Keep write frames from clobbering the last read result
            if (cmd.done && cmd.frame.op == MDIO_OP_READ) begin
                rdata_q <= cmd.rdata;
            end
        end
    end

    // Three-stage synchronizer for the PHY interrupt pin
    always_ff @(posedge clock) begin
        if (reset) begin
            phy_int_sync_q <= '0;
        end else begin
            phy_int_sync_q <= {phy_int_sync_q[1:0], phy_int_i};
        end
    end

    assign int_status[INT_MDIO_IDLE_BIT] = !cmd.busy;
    assign int_status[INT_PHY_BIT]       = phy_int_sync_q[2];

    assign irq_o       = |(int_enable_q & int_status);
    assign phy_reset_o = !ctrl_q;

    always_comb begin
        rd_mux = '0;
        case (addr)
            REG_CTRL:       rd_mux[CTRL_PHY_RUN_BIT] = ctrl_q;
            REG_INT_ENABLE: rd_mux[INT_COUNT-1:0] = int_enable_q;
            REG_INT_STATUS: rd_mux[INT_COUNT-1:0] = int_status;
            REG_MDIO_CMD:   rd_mux = cmd_q;
            REG_MDIO_RDATA: rd_mux = reg_data_t'(rdata_q);
            REG_STATUS:     rd_mux[STATUS_BUSY_BIT] = cmd.busy;
            default:        rd_mux = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            reg_rvalid_o <= 1'b0;
        end else begin
            reg_rvalid_o <= reg_rd_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reg_rd_i) begin
            reg_rdata_o <= rd_mux;
        end
    end

    // An accepted command must show up as busy on the next cycle
    assert property (@(posedge clock) disable iff (reset)
        cmd.start |-> !cmd.busy ##1 cmd.busy);

endmodule

//--- logic/mdio_cmd_if.sv
// Command and result bundle; start may only be raised while busy is low
`timescale 1ns/1ps

interface mdio_cmd_if
    import mdio_pkg::*;
();

    logic        start;
    mdio_frame_t frame;

    logic        busy;
    logic        done;
    mdio_data_t  rdata;

    modport regs (
        output start,
        output frame,
        input  busy,
        input  done,
        input  rdata
    );

    modport engine (
        input  start,
        output busy,
        output done,
        output rdata
    );

endinterface

//--- logic/mdio_pkg.sv
// Clause-22 frame layout only; Clause-45 opcodes and addressing are not supported
package mdio_pkg;

    typedef logic [15:0] mdio_data_t;

    typedef enum logic [1:0] {
        MDIO_OP_WRITE = 2'b01,
        MDIO_OP_READ  = 2'b10
    } mdio_op_e;

    // Sent MSB first, start field leads
    typedef struct packed {
        logic [1:0] st;
        mdio_op_e   op;
        logic [4:0] phy_addr;
        logic [4:0] reg_addr;
        logic [1:0] ta;
        mdio_data_t data;
    } mdio_frame_t;

    localparam int PREAMBLE_BITS = 32;
    localparam int FRAME_BITS    = 32;

    // Turnaround and data are driven by the PHY in a read
    localparam int READ_RELEASE_BIT = 14;

    typedef enum logic [1:0] {
        MDIO_IDLE,
        MDIO_PREAMBLE,
        MDIO_FRAME,
        MDIO_FINISH
    } mdio_state_e;

endpackage

//--- logic/regs_pkg.sv
// Register map of the MDIO block: byte addresses, 32-bit words, no byte enables
package regs_pkg;

    localparam int REG_ADDR_W = 8;
    localparam int REG_DATA_W = 32;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [REG_DATA_W-1:0] reg_data_t;

    typedef enum logic [REG_ADDR_W-1:0] {
        REG_CTRL       = 8'h00,
        REG_INT_ENABLE = 8'h04,
        REG_INT_STATUS = 8'h08,
        REG_MDIO_CMD   = 8'h0C,
        REG_MDIO_RDATA = 8'h10,
        REG_STATUS     = 8'h14
    } reg_addr_e;

    // Same positions in enable and status
    localparam int INT_MDIO_IDLE_BIT = 0;
    localparam int INT_PHY_BIT       = 1;
    localparam int INT_COUNT         = 2;

    // Single-bit fields of REG_CTRL and REG_STATUS
    localparam int CTRL_PHY_RUN_BIT = 0;
    localparam int STATUS_BUSY_BIT  = 0;

endpackage
